// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Word and register file geometry
`define coreDataWidth 32
`define coreRegCount 16
`define coreRegIndexWidth 4

// Registers with a fixed role
`define coreStackReg 0 // Stack pointer, grows upward
`define coreFlagsReg 1 // Compare flags

// Cycles from request edge to sampling edge
`define coreMemLatency 2

`define coreInstrBytes 4 // One instruction word

`endif

// ==== hdl/corePkg.sv ====
`include "core_settings.svh"

package corePkg;

  typedef logic [`coreDataWidth-1:0] wordT;
  typedef logic [`coreRegIndexWidth-1:0] regIndexT;

  // Byte 0 of the first instruction word
  typedef enum logic [7:0] {
    Stall = 8'd0, // Re-fetches itself
    MovRC = 8'd1,
    MovRR, MovRdC, MovRdRo, MovdCR, MovdRoR,
    AddRRR, AddRRC, SubRRR, SubRRC, IncR, DecR, ShlRRR, ShrRRR, NegRR,
    CmpRR, CmpRC, CmpERRR, CmpLtRRR,
    JmpC, JeC, JneC, JzRC, JnzRC,
    PushR, PopR, CallR, Ret,
    DoutR
  } opcodeT;

  typedef enum logic [2:0] {
    FetchIdle,
    FetchWaitOne,
    FetchCaptureOne,
    FetchWaitTwo,
    FetchCaptureTwo,
    FetchHold
  } fetchStateT;

  typedef enum logic [1:0] {
    MemIdle,
    MemWait,
    MemCapture,
    MemRetire
  } memStateT;

  // Opcodes with a second word holding a constant
  function automatic logic hasConstant(opcodeT op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR, AddRRC, SubRRC, CmpRC,
      JmpC, JeC, JneC, JzRC, JnzRC: hasConstant = 1'b1;
      default: hasConstant = 1'b0;
    endcase
  endfunction

endpackage

// ==== hdl/decodedIf.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

// Decoded instruction, fetch to execute stage
interface decodedIf;
  logic valid;
  logic ready;
  corePkg::opcodeT opcode;
  corePkg::regIndexT regA; // Byte 1 of word one
  corePkg::regIndexT regB; // Byte 2
  corePkg::regIndexT regC; // Byte 3
  corePkg::wordT dataWord; // Second word, zero for short forms
  corePkg::wordT pc;

  modport fetch(output valid, opcode, regA, regB, regC, dataWord, pc, input ready);
  modport execute(input valid, opcode, regA, regB, regC, dataWord, pc, output ready);
endinterface

// ==== hdl/execIf.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

// Resolved instruction, execute to memory stage
interface execIf;
  logic valid;
  logic ready;
  // Data access
  logic memRead;
  logic memWrite;
  corePkg::wordT address;
  corePkg::wordT storeData;
  // Main register write
  logic writeEnable;
  corePkg::regIndexT writeIndex;
  corePkg::wordT writeValue;
  logic writeFromLoad; // Take loaded word instead of writeValue
  // Stack pointer update
  logic spWrite;
  corePkg::wordT spValue;
  // Next fetch
  corePkg::wordT nextPc;
  logic pcFromLoad; // Ret, loaded return address plus 4
  logic doutValid;
  corePkg::wordT doutValue;

  modport execute(output valid, memRead, memWrite, address, storeData, writeEnable,
    writeIndex, writeValue, writeFromLoad, spWrite, spValue, nextPc, pcFromLoad,
    doutValid, doutValue, input ready);
  modport memory(input valid, memRead, memWrite, address, storeData, writeEnable,
    writeIndex, writeValue, writeFromLoad, spWrite, spValue, nextPc, pcFromLoad,
    doutValid, doutValue, output ready);
endinterface

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module fetchStage (
  input  logic clk,
  input  logic reset,
  input  logic redirectValid,
  input  corePkg::wordT redirectPc,
  output corePkg::wordT instrAddress,
  output logic instrReadReq,
  input  corePkg::wordT instrData,
  decodedIf.fetch decoded
);

  corePkg::fetchStateT state;
  corePkg::wordT pc;
  logic bootPending; // First fetch after reset needs no redirect
  logic startFetch;
  corePkg::wordT startPc;
  corePkg::opcodeT fetchedOp;

  assign startFetch = redirectValid || bootPending;
  assign startPc = redirectValid ? redirectPc : pc;
  assign fetchedOp = corePkg::opcodeT'(instrData[7:0]);
  assign decoded.pc = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= corePkg::FetchIdle;
      pc <= '0;
      bootPending <= 1'b1;
      instrReadReq <= 1'b0;
      decoded.valid <= 1'b0;
    end else begin
      if (decoded.valid && decoded.ready) decoded.valid <= 1'b0; // Taken by execute
      case (state)
        corePkg::FetchIdle, corePkg::FetchHold: begin
          if (startFetch) begin
            bootPending <= 1'b0;
            pc <= startPc;
            instrAddress <= startPc;
            instrReadReq <= 1'b1; // Single-cycle request
            state <= corePkg::FetchWaitOne;
          end
        end
        corePkg::FetchWaitOne: begin
          instrReadReq <= 1'b0;
          if (!instrReadReq) state <= corePkg::FetchCaptureOne; // Request edge passed
        end
        corePkg::FetchCaptureOne: begin
          decoded.opcode <= fetchedOp;
          decoded.regA <= instrData[8 +: `coreRegIndexWidth]; // Low four bits of each field
          decoded.regB <= instrData[16 +: `coreRegIndexWidth];
          decoded.regC <= instrData[24 +: `coreRegIndexWidth];
          if (corePkg::hasConstant(fetchedOp)) begin
            // Constant follows in the next word
            instrAddress <= pc + `coreInstrBytes;
            instrReadReq <= 1'b1;
            state <= corePkg::FetchWaitTwo;
          end else begin
            decoded.dataWord <= '0;
            decoded.valid <= 1'b1;
            state <= corePkg::FetchHold;
          end
        end
        corePkg::FetchWaitTwo: begin
          instrReadReq <= 1'b0;
          if (!instrReadReq) state <= corePkg::FetchCaptureTwo;
        end
        corePkg::FetchCaptureTwo: begin
          decoded.dataWord <= instrData;
          decoded.valid <= 1'b1;
          state <= corePkg::FetchHold; // Wait here for retire
        end
        default: state <= corePkg::FetchIdle;
      endcase
    end
  end

  // Memory has no back-pressure, so each request is a one-cycle pulse
  assert property (@(posedge clk) disable iff (reset) instrReadReq |=> !instrReadReq);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module regFile (
  input  logic clk,
  input  logic reset,
  input  logic [`coreRegIndexWidth-1:0] readIndexA,
  input  logic [`coreRegIndexWidth-1:0] readIndexB,
  input  logic [`coreRegIndexWidth-1:0] readIndexC,
  output logic [`coreDataWidth-1:0] readValueA,
  output logic [`coreDataWidth-1:0] readValueB,
  output logic [`coreDataWidth-1:0] readValueC,
  output logic [`coreDataWidth-1:0] stackPointer,
  output logic [`coreDataWidth-1:0] flags,
  input  logic writeEnable,
  input  logic [`coreRegIndexWidth-1:0] writeIndex,
  input  logic [`coreDataWidth-1:0] writeValue,
  input  logic stackWrite,
  input  logic [`coreDataWidth-1:0] stackValue
);

  logic [`coreDataWidth-1:0] regs [`coreRegCount];

  // Combinational reads
  assign readValueA = regs[readIndexA];
  assign readValueB = regs[readIndexB];
  assign readValueC = regs[readIndexC];
  assign stackPointer = regs[`coreStackReg];
  assign flags = regs[`coreFlagsReg];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `coreRegCount; i++) regs[i] <= '0;
    end else begin
      if (writeEnable) regs[writeIndex] <= writeValue;
      if (stackWrite) regs[`coreStackReg] <= stackValue; // Last assignment wins
    end
  end

  // Retire never targets the stack pointer from both write ports
  assert property (@(posedge clk) disable iff (reset)
    !(stackWrite && writeEnable && writeIndex == `coreRegIndexWidth'(`coreStackReg)));

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module executeStage (
  input  logic clk,
  input  logic reset,
  decodedIf.execute decoded,
  execIf.execute resolved,
  output corePkg::regIndexT readIndexA,
  output corePkg::regIndexT readIndexB,
  output corePkg::regIndexT readIndexC,
  input  corePkg::wordT readValueA,
  input  corePkg::wordT readValueB,
  input  corePkg::wordT readValueC,
  input  corePkg::wordT stackPointer,
  input  corePkg::wordT flags
);

  logic busy; // Holding an instruction for the memory stage
  corePkg::opcodeT op;
  corePkg::regIndexT regA;
  corePkg::wordT pc;
  corePkg::wordT constWord;
  corePkg::wordT valA;
  corePkg::wordT valB;
  corePkg::wordT valC;
  corePkg::wordT sp;
  corePkg::wordT flagWord;
  corePkg::wordT aluResult;
  corePkg::wordT cmpRight;
  corePkg::wordT fallThrough;
  logic [2:0] cmpFlags; // Greater, less, equal
  logic taken;

  // Register fields go straight to the read ports
  assign readIndexA = decoded.regA;
  assign readIndexB = decoded.regB;
  assign readIndexC = decoded.regC;
  assign decoded.ready = !busy;
  assign resolved.valid = busy;

  always_ff @(posedge clk) begin
    if (reset) busy <= 1'b0;
    else if (decoded.valid && decoded.ready) busy <= 1'b1;
    else if (resolved.valid && resolved.ready) busy <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (decoded.valid && decoded.ready) begin
      op <= decoded.opcode;
      regA <= decoded.regA;
      pc <= decoded.pc;
      constWord <= decoded.dataWord;
      valA <= readValueA; // Operands sampled with the instruction
      valB <= readValueB;
      valC <= readValueC;
      sp <= stackPointer;
      flagWord <= flags;
    end
  end

  assign cmpRight = (op == corePkg::CmpRC) ? constWord : valB;
  assign cmpFlags = {valA > cmpRight, valA < cmpRight, valA == cmpRight}; // Unsigned
  assign fallThrough = pc + (corePkg::hasConstant(op) ? 2 * `coreInstrBytes : `coreInstrBytes);

  always_comb begin
    case (op)
      corePkg::MovRC: aluResult = constWord;
      corePkg::MovRR: aluResult = valB;
      corePkg::AddRRR: aluResult = valB + valC;
      corePkg::AddRRC: aluResult = valB + constWord;
      corePkg::SubRRR: aluResult = valB - valC;
      corePkg::SubRRC: aluResult = valB - constWord;
      corePkg::IncR: aluResult = valA + 1;
      corePkg::DecR: aluResult = valA - 1;
      corePkg::ShlRRR: aluResult = valB << valC;
      corePkg::ShrRRR: aluResult = valB >> valC;
      corePkg::NegRR: aluResult = -valB;
      corePkg::CmpERRR: aluResult = corePkg::wordT'(valB == valC);
      corePkg::CmpLtRRR: aluResult = corePkg::wordT'(valB < valC);
      corePkg::CmpRR, corePkg::CmpRC: aluResult = corePkg::wordT'(cmpFlags);
      default: aluResult = '0;
    endcase
  end

  assign resolved.writeValue = aluResult;
  assign resolved.doutValue = valA;

  always_comb begin
    resolved.memRead = 1'b0;
    resolved.memWrite = 1'b0;
    resolved.address = constWord; // Absolute address by default
    resolved.storeData = valB;
    resolved.writeEnable = 1'b0;
    resolved.writeIndex = regA;
    resolved.writeFromLoad = 1'b0;
    resolved.spWrite = 1'b0;
    resolved.spValue = sp + `coreInstrBytes; // Push direction
    resolved.pcFromLoad = 1'b0;
    resolved.doutValid = 1'b0;
    taken = 1'b0;
    case (op)
      corePkg::MovRC, corePkg::MovRR, corePkg::AddRRR, corePkg::AddRRC, corePkg::SubRRR,
      corePkg::SubRRC, corePkg::IncR, corePkg::DecR, corePkg::ShlRRR, corePkg::ShrRRR,
      corePkg::NegRR, corePkg::CmpERRR, corePkg::CmpLtRRR: resolved.writeEnable = 1'b1;
      corePkg::CmpRR, corePkg::CmpRC: begin
        resolved.writeEnable = 1'b1;
        resolved.writeIndex = corePkg::regIndexT'(`coreFlagsReg);
      end
      corePkg::MovRdC, corePkg::MovRdRo: begin
        resolved.memRead = 1'b1;
        if (op == corePkg::MovRdRo) resolved.address = constWord + valB; // Base in B
        resolved.writeEnable = 1'b1;
        resolved.writeFromLoad = 1'b1;
      end
      corePkg::MovdCR: resolved.memWrite = 1'b1;
      corePkg::MovdRoR: begin
        resolved.memWrite = 1'b1;
        resolved.address = constWord + valA; // Base in A, data in B
      end
      corePkg::JmpC: taken = 1'b1;
      corePkg::JeC: taken = flagWord[0];
      corePkg::JneC: taken = !flagWord[0];
      corePkg::JzRC: taken = (valC == '0); // Tested register sits in field C
      corePkg::JnzRC: taken = (valC != '0);
      corePkg::PushR, corePkg::CallR: begin
        resolved.memWrite = 1'b1;
        resolved.address = sp; // Stack pointer marks the free slot
        resolved.storeData = (op == corePkg::CallR) ? pc : valA;
        resolved.spWrite = 1'b1;
      end
      corePkg::PopR, corePkg::Ret: begin
        resolved.memRead = 1'b1;
        resolved.address = sp - `coreInstrBytes;
        resolved.spWrite = 1'b1;
        resolved.spValue = sp - `coreInstrBytes;
        resolved.writeEnable = (op == corePkg::PopR);
        resolved.writeFromLoad = (op == corePkg::PopR);
        resolved.pcFromLoad = (op == corePkg::Ret);
      end
      corePkg::DoutR: resolved.doutValid = 1'b1;
      default: ; // Stall and unknown opcodes
    endcase
    if (taken) resolved.nextPc = constWord;
    else if (op == corePkg::CallR) resolved.nextPc = valA;
    else if (op == corePkg::Stall) resolved.nextPc = pc; // Spin on itself
    else resolved.nextPc = fallThrough;
  end

endmodule

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module memoryStage (
  input  logic clk,
  input  logic reset,
  execIf.memory resolved,
  output corePkg::wordT ramAddress,
  output corePkg::wordT ramOut,
  output logic readReq,
  output logic writeReq,
  input  corePkg::wordT ramIn,
  output logic writeEnable,
  output corePkg::regIndexT writeIndex,
  output corePkg::wordT writeValue,
  output logic stackWrite,
  output corePkg::wordT stackValue,
  output logic redirectValid,
  output corePkg::wordT redirectPc,
  output corePkg::wordT debugOut,
  output logic debugValid
);

  corePkg::memStateT state;
  logic retire;
  logic isLoad;
  logic wbEnable;
  logic wbFromLoad;
  corePkg::regIndexT wbIndex;
  corePkg::wordT wbValue;
  logic spWriteHeld;
  corePkg::wordT spValueHeld;
  corePkg::wordT nextPcHeld;
  logic pcFromLoadHeld;
  logic doutValidHeld;
  corePkg::wordT doutValueHeld;
  corePkg::wordT loadData;

  assign resolved.ready = (state == corePkg::MemIdle);
  assign retire = (state == corePkg::MemRetire);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= corePkg::MemIdle;
      readReq <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      case (state)
        corePkg::MemIdle: begin
          if (resolved.valid) begin
            readReq <= resolved.memRead;
            writeReq <= resolved.memWrite;
            state <= (resolved.memRead || resolved.memWrite) ? corePkg::MemWait
                                                             : corePkg::MemRetire;
          end
        end
        corePkg::MemWait: begin
          readReq <= 1'b0;
          writeReq <= 1'b0;
          // Leave once the request edge is behind us
          if (!readReq && !writeReq) state <= isLoad ? corePkg::MemCapture : corePkg::MemRetire;
        end
        corePkg::MemCapture: state <= corePkg::MemRetire; // Second edge after request
        default: state <= corePkg::MemIdle; // Retire lasts one cycle
      endcase
    end
  end

  // Payload held from accept to retire
  always_ff @(posedge clk) begin
    if (resolved.valid && resolved.ready) begin
      ramAddress <= resolved.address;
      ramOut <= resolved.storeData;
      isLoad <= resolved.memRead;
      wbEnable <= resolved.writeEnable;
      wbIndex <= resolved.writeIndex;
      wbValue <= resolved.writeValue;
      wbFromLoad <= resolved.writeFromLoad;
      spWriteHeld <= resolved.spWrite;
      spValueHeld <= resolved.spValue;
      nextPcHeld <= resolved.nextPc;
      pcFromLoadHeld <= resolved.pcFromLoad;
      doutValidHeld <= resolved.doutValid;
      doutValueHeld <= resolved.doutValue;
    end
    if (state == corePkg::MemCapture) loadData <= ramIn;
  end

  // Everything below is visible only during the retire cycle
  assign writeEnable = retire && wbEnable;
  assign writeIndex = wbIndex;
  assign writeValue = wbFromLoad ? loadData : wbValue;
  assign stackWrite = retire && spWriteHeld;
  assign stackValue = spValueHeld;
  assign redirectValid = retire; // Starts the next fetch
  assign redirectPc = pcFromLoadHeld ? loadData + `coreInstrBytes : nextPcHeld; // Ret skips CallR
  assign debugValid = retire && doutValidHeld;
  assign debugOut = doutValueHeld;

  // Execute never resolves an instruction as both load and store
  assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq));

endmodule

// ==== hdl/phaethonCore.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module phaethonCore (
  input  logic clk,
  input  logic reset,
  output corePkg::wordT instrAddress,
  output logic instrReadReq,
  input  corePkg::wordT instrData,
  output corePkg::wordT ramAddress,
  output corePkg::wordT ramOut,
  output logic readReq,
  output logic writeReq,
  input  corePkg::wordT ramIn,
  output corePkg::wordT debugOut,
  output logic debugValid
);

  decodedIf decodedBus();
  execIf execBus();

  // Retire back to fetch
  logic redirectValid;
  corePkg::wordT redirectPc;

  // Register file reads by execute
  corePkg::regIndexT readIndexA;
  corePkg::regIndexT readIndexB;
  corePkg::regIndexT readIndexC;
  corePkg::wordT readValueA;
  corePkg::wordT readValueB;
  corePkg::wordT readValueC;
  corePkg::wordT stackPointer;
  corePkg::wordT flags;

  // Register file writes by memory stage
  logic writeEnable;
  corePkg::regIndexT writeIndex;
  corePkg::wordT writeValue;
  logic stackWrite;
  corePkg::wordT stackValue;

  fetchStage fetch (
    .clk(clk), .reset(reset),
    .redirectValid(redirectValid), .redirectPc(redirectPc),
    .instrAddress(instrAddress), .instrReadReq(instrReadReq), .instrData(instrData),
    .decoded(decodedBus.fetch)
  );

  executeStage execute (
    .clk(clk), .reset(reset),
    .decoded(decodedBus.execute), .resolved(execBus.execute),
    .readIndexA(readIndexA), .readIndexB(readIndexB), .readIndexC(readIndexC),
    .readValueA(readValueA), .readValueB(readValueB), .readValueC(readValueC),
    .stackPointer(stackPointer), .flags(flags)
  );

  memoryStage memory (
    .clk(clk), .reset(reset),
    .resolved(execBus.memory),
    .ramAddress(ramAddress), .ramOut(ramOut), .readReq(readReq), .writeReq(writeReq),
    .ramIn(ramIn),
    .writeEnable(writeEnable), .writeIndex(writeIndex), .writeValue(writeValue),
    .stackWrite(stackWrite), .stackValue(stackValue),
    .redirectValid(redirectValid), .redirectPc(redirectPc),
    .debugOut(debugOut), .debugValid(debugValid)
  );

  regFile registers (
    .clk(clk), .reset(reset),
    .readIndexA(readIndexA), .readIndexB(readIndexB), .readIndexC(readIndexC),
    .readValueA(readValueA), .readValueB(readValueB), .readValueC(readValueC),
    .stackPointer(stackPointer), .flags(flags),
    .writeEnable(writeEnable), .writeIndex(writeIndex), .writeValue(writeValue),
    .stackWrite(stackWrite), .stackValue(stackValue)
  );

endmodule

// ==== verif/coreTb.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module coreTb;

  logic clk;
  logic reset;
  corePkg::wordT instrAddress;
  logic instrReadReq;
  corePkg::wordT instrData;
  corePkg::wordT ramAddress;
  corePkg::wordT ramOut;
  logic readReq;
  logic writeReq;
  corePkg::wordT ramIn;
  corePkg::wordT debugOut;
  logic debugValid;

  corePkg::wordT mem [1024]; // Shared by both ports and indexed by word
  corePkg::wordT refMem [1024];
  corePkg::wordT instrPipe [`coreMemLatency]; // Read data on its way to instrData
  corePkg::wordT loadPipe [`coreMemLatency];
  logic [`coreMemLatency-1:0] instrLive; // Marks pipe slots that follow a request
  logic [`coreMemLatency-1:0] loadLive;
  corePkg::wordT refOut[$];
  corePkg::wordT gotOut[$];
  int asmPos; // Word index of next assembled word
  corePkg::wordT stallAddr;
  int errors;
  int testsRun;
  int testsFailed;

  phaethonCore dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory model with data present only in the cycle before the sampling edge
  always @(negedge clk) begin
    instrData <= instrLive[`coreMemLatency-1] ? instrPipe[`coreMemLatency-1] : '1;
    ramIn <= loadLive[`coreMemLatency-1] ? loadPipe[`coreMemLatency-1] : '1; // All ones off-slot
    instrPipe[0] <= mem[instrAddress[11:2]];
    loadPipe[0] <= mem[ramAddress[11:2]];
    for (int i = 1; i < `coreMemLatency; i++) begin
      instrPipe[i] <= instrPipe[i-1];
      loadPipe[i] <= loadPipe[i-1];
    end
    instrLive <= {instrLive[`coreMemLatency-2:0], instrReadReq};
    loadLive <= {loadLive[`coreMemLatency-2:0], readReq};
    if (writeReq) mem[ramAddress[11:2]] <= ramOut; // Commits at request edge
    if (!reset && debugValid) gotOut.push_back(debugOut);
  end

  function automatic void fillMemory();
    for (int i = 0; i < 1024; i++) mem[i] = (i * 32'h9e3779b9) ^ (i << 7) ^ 32'h5a5a0000;
  endfunction

  function automatic void emit(corePkg::opcodeT op, int a, int b, int c);
    mem[asmPos] = {c[7:0], b[7:0], a[7:0], 8'(op)};
    asmPos++;
  endfunction

  // Returns the word index of the constant so jumps can be patched
  function automatic int emitK(corePkg::opcodeT op, int a, int b, int c, corePkg::wordT k);
    emit(op, a, b, c);
    mem[asmPos] = k;
    asmPos++;
    return asmPos - 1;
  endfunction

  function automatic void halt();
    stallAddr = asmPos * 4;
    emit(corePkg::Stall, 0, 0, 0);
  endfunction

  // ISA interpreter that runs on refMem and fills refOut
  function automatic void interpret();
    corePkg::wordT r [16];
    corePkg::wordT pc;
    corePkg::wordT w;
    corePkg::wordT k;
    corePkg::wordT nxt;
    corePkg::wordT x;
    corePkg::opcodeT op;
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] c;
    logic long;
    for (int i = 0; i < 16; i++) r[i] = '0;
    pc = '0;
    refOut.delete();
    for (int step = 0; step < 20000; step++) begin
      w = refMem[pc[11:2]];
      op = corePkg::opcodeT'(w[7:0]);
      a = w[11:8];
      b = w[19:16];
      c = w[27:24];
      k = refMem[pc[11:2] + 10'd1];
      long = op inside {corePkg::MovRC, corePkg::MovRdC, corePkg::MovRdRo, corePkg::MovdCR,
        corePkg::MovdRoR, corePkg::AddRRC, corePkg::SubRRC, corePkg::CmpRC, corePkg::JmpC,
        corePkg::JeC, corePkg::JneC, corePkg::JzRC, corePkg::JnzRC};
      nxt = pc + (long ? 8 : 4);
      x = (op == corePkg::CmpRC) ? k : r[b];
      case (op)
        corePkg::Stall: return;
        corePkg::MovRC: r[a] = k;
        corePkg::MovRR: r[a] = r[b];
        corePkg::MovRdC: r[a] = refMem[k[11:2]];
        corePkg::MovRdRo: r[a] = refMem[(k + r[b]) >> 2];
        corePkg::MovdCR: refMem[k[11:2]] = r[b];
        corePkg::MovdRoR: refMem[(k + r[a]) >> 2] = r[b];
        corePkg::AddRRR: r[a] = r[b] + r[c];
        corePkg::AddRRC: r[a] = r[b] + k;
        corePkg::SubRRR: r[a] = r[b] - r[c];
        corePkg::SubRRC: r[a] = r[b] - k;
        corePkg::IncR: r[a] = r[a] + 1;
        corePkg::DecR: r[a] = r[a] - 1;
        corePkg::ShlRRR: r[a] = r[b] << r[c];
        corePkg::ShrRRR: r[a] = r[b] >> r[c];
        corePkg::NegRR: r[a] = 0 - r[b];
        corePkg::CmpRR, corePkg::CmpRC: r[1] = {29'd0, r[a] > x, r[a] < x, r[a] == x};
        corePkg::CmpERRR: r[a] = (r[b] == r[c]) ? 1 : 0;
        corePkg::CmpLtRRR: r[a] = (r[b] < r[c]) ? 1 : 0;
        corePkg::JmpC: nxt = k;
        corePkg::JeC: if (r[1][0]) nxt = k;
        corePkg::JneC: if (!r[1][0]) nxt = k;
        corePkg::JzRC: if (r[c] == 0) nxt = k;
        corePkg::JnzRC: if (r[c] != 0) nxt = k;
        corePkg::PushR: begin
          refMem[r[0] >> 2] = r[a];
          r[0] = r[0] + 4;
        end
        corePkg::CallR: begin
          nxt = r[a];
          refMem[r[0] >> 2] = pc;
          r[0] = r[0] + 4;
        end
        corePkg::PopR: begin
          r[0] = r[0] - 4;
          r[a] = refMem[r[0] >> 2];
        end
        corePkg::Ret: begin
          r[0] = r[0] - 4;
          nxt = refMem[r[0] >> 2] + 4; // Skip the CallR
        end
        corePkg::DoutR: refOut.push_back(r[a]);
        default: ;
      endcase
      pc = nxt;
    end
  endfunction

  task automatic resetCore(input string name);
    int cycles;
    @(negedge clk);
    reset = 1'b1;
    gotOut.delete();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!instrReadReq && cycles < 20) begin // First fetch after reset
      assert (!readReq && !writeReq && !debugValid) else begin
        $display("%s: data request or debug output active right after reset", name);
        errors++;
      end
      @(negedge clk);
      cycles++;
    end
    assert (instrReadReq) else begin
      $display("%s: no instruction fetch after reset", name);
      errors++;
    end
    assert (instrAddress == 0) else begin
      $display("mismatch %s first fetch: expected %h actual %h", name, 32'h0, instrAddress);
      errors++;
    end
  endtask

  task automatic runTest(input string name);
    int cycles;
    int memErrors;
    errors = 0;
    memErrors = 0;
    refMem = mem;
    interpret();
    resetCore(name);
    cycles = 0;
    while (!(instrReadReq && instrAddress == stallAddr) && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    assert (cycles < 20000) else begin
      $display("%s: timed out waiting for the core to reach its halt", name);
      errors++;
    end
    assert (gotOut.size() == refOut.size()) else begin
      $display("mismatch %s output count: expected %0d actual %0d", name,
        refOut.size(), gotOut.size());
      errors++;
    end
    for (int i = 0; i < refOut.size() && i < gotOut.size(); i++)
      assert (gotOut[i] == refOut[i]) else begin
        $display("mismatch %s output %0d: expected %h actual %h", name, i, refOut[i], gotOut[i]);
        errors++;
      end
    for (int i = 0; i < 1024; i++)
      assert (mem[i] == refMem[i]) else begin
        if (memErrors < 4)
          $display("mismatch %s word %h: expected %h actual %h", name, i * 4, refMem[i], mem[i]);
        memErrors++;
        errors++;
      end
    testsRun++;
    if (errors != 0) testsFailed++;
    $display("test %s: %s (%0d errors)", name, (errors == 0) ? "ok" : "failed", errors);
  endtask

  task automatic newProgram();
    fillMemory();
    asmPos = 0;
  endtask

  initial begin
    int p1;
    int p2;
    int top;
    corePkg::opcodeT aluOps [9];
    reset = 1'b1;
    instrData = '0;
    ramIn = '0;
    instrLive = '0;
    loadLive = '0;
    testsRun = 0;
    testsFailed = 0;
    void'($urandom(63));
    aluOps = '{corePkg::AddRRR, corePkg::AddRRC, corePkg::SubRRR, corePkg::SubRRC,
      corePkg::IncR, corePkg::DecR, corePkg::ShlRRR, corePkg::ShrRRR, corePkg::NegRR};

    newProgram();
    halt();
    runTest("reset");

    newProgram();
    p1 = emitK(corePkg::MovRC, 2, 0, 0, 100);
    p1 = emitK(corePkg::MovRC, 3, 0, 0, 7);
    emit(corePkg::AddRRR, 4, 2, 3);
    p1 = emitK(corePkg::SubRRC, 5, 4, 0, 3);
    emit(corePkg::ShlRRR, 6, 3, 3);
    emit(corePkg::ShrRRR, 7, 2, 3);
    emit(corePkg::IncR, 4, 0, 0);
    emit(corePkg::DecR, 5, 0, 0);
    emit(corePkg::NegRR, 8, 2, 0);
    emit(corePkg::MovRR, 9, 8, 0);
    for (int i = 4; i <= 9; i++) emit(corePkg::DoutR, i, 0, 0);
    p1 = emitK(corePkg::MovdCR, 0, 4, 0, 32'h800);
    p1 = emitK(corePkg::MovdCR, 0, 9, 0, 32'h804);
    halt();
    runTest("moves_arith");

    newProgram();
    p1 = emitK(corePkg::MovRC, 2, 0, 0, 32'h810);
    p1 = emitK(corePkg::MovRC, 3, 0, 0, 55);
    p1 = emitK(corePkg::MovdRoR, 2, 3, 0, 8); // Store to base plus offset
    p1 = emitK(corePkg::MovRdRo, 4, 2, 0, 8);
    emit(corePkg::DoutR, 4, 0, 0);
    p1 = emitK(corePkg::MovRdC, 5, 0, 0, 32'h818);
    emit(corePkg::DoutR, 5, 0, 0);
    p1 = emitK(corePkg::MovdCR, 0, 5, 0, 32'h820);
    p1 = emitK(corePkg::MovRdC, 6, 0, 0, 32'h900); // Fill pattern word
    emit(corePkg::DoutR, 6, 0, 0);
    p1 = emitK(corePkg::MovdRoR, 2, 6, 0, 32'h40);
    halt();
    runTest("load_store");

    newProgram();
    p1 = emitK(corePkg::MovRC, 2, 0, 0, 0);
    p1 = emitK(corePkg::MovRC, 3, 0, 0, 5);
    top = asmPos * 4; // Counted loop head
    emit(corePkg::IncR, 2, 0, 0);
    emit(corePkg::DoutR, 2, 0, 0);
    emit(corePkg::CmpRR, 2, 3, 0);
    p1 = emitK(corePkg::JneC, 0, 0, 0, top);
    p1 = emitK(corePkg::CmpRC, 2, 0, 0, 5);
    p1 = emitK(corePkg::JeC, 0, 0, 0, 0);
    emit(corePkg::DoutR, 3, 0, 0); // Skipped
    mem[p1] = asmPos * 4;
    p2 = emitK(corePkg::MovRC, 4, 0, 0, 3);
    top = asmPos * 4;
    emit(corePkg::DecR, 4, 0, 0);
    emit(corePkg::CmpLtRRR, 5, 4, 3);
    emit(corePkg::DoutR, 5, 0, 0);
    p2 = emitK(corePkg::JnzRC, 0, 0, 4, top);
    emit(corePkg::CmpERRR, 6, 2, 3);
    emit(corePkg::DoutR, 6, 0, 0);
    p2 = emitK(corePkg::JzRC, 0, 0, 6, 0); // Not taken
    halt();
    runTest("compare_jump");

    newProgram();
    p1 = emitK(corePkg::MovRC, 0, 0, 0, 32'hC00);
    p1 = emitK(corePkg::MovRC, 2, 0, 0, 11);
    emit(corePkg::PushR, 2, 0, 0);
    p1 = emitK(corePkg::MovRC, 3, 0, 0, 0);
    emit(corePkg::CallR, 3, 0, 0);
    emit(corePkg::PopR, 4, 0, 0);
    emit(corePkg::DoutR, 4, 0, 0);
    halt();
    mem[p1] = asmPos * 4; // Outer routine
    p2 = emitK(corePkg::MovRC, 5, 0, 0, 22);
    emit(corePkg::PushR, 5, 0, 0);
    p2 = emitK(corePkg::MovRC, 6, 0, 0, 0);
    emit(corePkg::CallR, 6, 0, 0);
    emit(corePkg::PopR, 7, 0, 0);
    emit(corePkg::DoutR, 7, 0, 0);
    emit(corePkg::Ret, 0, 0, 0);
    mem[p2] = asmPos * 4; // Inner routine
    emit(corePkg::DoutR, 5, 0, 0);
    emit(corePkg::Ret, 0, 0, 0);
    runTest("stack");

    for (int t = 0; t < 3; t++) begin
      newProgram();
      for (int i = 2; i <= 4; i++) p1 = emitK(corePkg::MovRC, i, 0, 0, $urandom);
      for (int i = 5; i <= 7; i++) p1 = emitK(corePkg::MovRC, i, 0, 0, $urandom % 40);
      for (int n = 0; n < 12; n++) begin
        top = 2 + $urandom % 6;
        p2 = $urandom % 9;
        if (aluOps[p2] == corePkg::AddRRC || aluOps[p2] == corePkg::SubRRC)
          p1 = emitK(aluOps[p2], top, 2 + $urandom % 6, 0, $urandom);
        else
          emit(aluOps[p2], top, 2 + $urandom % 6, 2 + $urandom % 6);
        emit(corePkg::DoutR, top, 0, 0);
      end
      halt();
      runTest($sformatf("random_alu_%0d", t));
    end

    $display("tests run %0d, failed %0d", testsRun, testsFailed);
    if (testsFailed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
hdl/corePkg.sv
hdl/decodedIf.sv
hdl/execIf.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/phaethonCore.sv
verif/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module coreTb -o coreSim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/coreSim > sim.log 2>&1 || echo "simulation exited with an error"
grep -q "TB PASSED" sim.log && echo "simulation passed" && exit 0 || {
  echo "simulation failed, see sim.log"
  exit 1
}
